/* Makefile */
TOP := tb_rf_ecc

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module rf_ecc_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/tb_rf_ecc_tests.svh */
`ifndef TB_RF_ECC_TESTS_SVH
`define TB_RF_ECC_TESTS_SVH

// Every register reads back as encoded zero, alert stays low
task automatic test_reset_state();
  begin_test("reset_state");
  for (int i = 0; i < `RF_NUM_REGS; i++) begin
    read_pair(rf_addr_t'(i), rf_addr_t'(`RF_NUM_REGS - 1 - i));
  end
  wait_drain();
  check_value("alert", 32'd0, 32'(alert_major_o));
  end_test();
endtask

// Random writes, some aimed at index 0, then read everything back
task automatic test_random_writes();
  rf_addr_t addr;
  begin_test("random_writes");
  for (int n = 0; n < T2_WRITES; n++) begin
    // Every eighth write targets the hardwired register
    if (n % 8 == 0) begin
      addr = '0;
    end else begin
      addr = rf_addr_t'($urandom_range(0, `RF_NUM_REGS - 1));
    end
    write_reg(addr, $urandom);
  end
  for (int i = 0; i < `RF_NUM_REGS; i++) begin
    read_pair(rf_addr_t'(i), rf_addr_t'($urandom_range(0, `RF_NUM_REGS - 1)));
  end
  wait_drain();
  check_value("alert", 32'd0, 32'(alert_major_o));
  end_test();
endtask

// One and two bit glitches on a single register
task automatic test_xor_faults();
  rf_addr_t bad_reg;
  rf_addr_t good_reg;
  rf_cw_t   mask;
  int       bit_a;
  int       bit_b;
  begin_test("xor_faults");
  bad_reg  = 5'd5;
  good_reg = 5'd6;
  write_reg(bad_reg, $urandom);
  write_reg(good_reg, $urandom);
  check_value("alert before fault", 32'd0, 32'(alert_major_o));
  // Single flip anywhere in the 38 bits
  bit_a = $urandom_range(0, `RF_ECC_W + `RF_DATA_W - 1);
  mask = '0;
  mask[bit_a] = 1'b1;
  inject_fault(bad_reg, RF_FAULT_XOR, mask);
  read_pair(bad_reg, good_reg);
  read_pair(good_reg, bad_reg);
  wait_drain();
  check_value("alert after 1 bit", 32'd1, 32'(alert_major_o));
  // Rewrite clears the glitch, then two distinct flips
  write_reg(bad_reg, $urandom);
  bit_a = $urandom_range(0, `RF_ECC_W + `RF_DATA_W - 1);
  bit_b = (bit_a + $urandom_range(1, `RF_ECC_W + `RF_DATA_W - 1)) % (`RF_ECC_W + `RF_DATA_W);
  mask = '0;
  mask[bit_a] = 1'b1;
  mask[bit_b] = 1'b1;
  inject_fault(bad_reg, RF_FAULT_XOR, mask);
  read_pair(bad_reg, good_reg);
  read_pair(good_reg, bad_reg);
  wait_drain();
  check_value("alert stays high", 32'd1, 32'(alert_major_o));
  end_test();
endtask

// Stuck words must fail the check even with plausible data
task automatic test_forced_words();
  begin_test("forced_words");
  write_reg(5'd9, $urandom);
  write_reg(5'd10, $urandom);
  inject_fault(5'd9, RF_FAULT_ZERO, '0);
  inject_fault(5'd10, RF_FAULT_ONE, '0);
  read_pair(5'd9, 5'd10);
  read_pair(5'd10, 5'd9);
  wait_drain();
  end_test();
endtask

// Consumer withholds credits, then returns them with random stalls
task automatic test_backpressure();
  int seen_base;
  int pulse_base;
  begin_test("backpressure");
  seen_base  = rsp_seen;
  pulse_base = credit_pulses;
  @(posedge clk_i);
  hold_credits = 1'b1;
  for (int i = 0; i < `RF_REQ_CREDITS; i++) begin
    read_pair(rf_addr_t'($urandom_range(0, `RF_NUM_REGS - 1)),
              rf_addr_t'($urandom_range(0, `RF_NUM_REGS - 1)));
  end
  repeat (HOLD_CYCLES) @(negedge clk_i);
  check_count++;
  assert ((rsp_seen - seen_base) <= `RF_RSP_CREDITS) else begin
    $display("Fail %s responses while held expected at most %0d actual %0d",
             test_name, `RF_RSP_CREDITS, rsp_seen - seen_base);
    err_count++;
  end
  @(posedge clk_i);
  hold_credits = 1'b0;
  random_stall = 1'b1;
  for (int i = `RF_REQ_CREDITS; i < T5_READS; i++) begin
    read_pair(rf_addr_t'($urandom_range(0, `RF_NUM_REGS - 1)),
              rf_addr_t'($urandom_range(0, `RF_NUM_REGS - 1)));
  end
  wait_drain();
  check_value("responses", 32'(T5_READS), 32'(rsp_seen - seen_base));
  check_value("request credit pulses", 32'(T5_READS), 32'(credit_pulses - pulse_base));
  check_value("request credits held", 32'(`RF_REQ_CREDITS), 32'(req_credits));
  @(posedge clk_i);
  random_stall = 1'b0;
  end_test();
endtask

`endif

/* dv/tb_rf_ecc.sv */
`include "rf_ecc_macros.svh"

module tb_rf_ecc import rf_ecc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int unsigned SEED = 32'h7f8e_0d8b;
  // Operation counts per test, also size the watchdog
  localparam int T2_WRITES = 40;
  localparam int T5_READS  = 20;
  localparam int NUM_TXN   = `RF_NUM_REGS + T2_WRITES + `RF_NUM_REGS + 12 + 6 + T5_READS;
  localparam int HOLD_CYCLES    = 24;
  localparam int CYCLES_PER_TXN = 16;
  localparam int WATCHDOG_NS =
    (RESET_CYCLES + HOLD_CYCLES + NUM_TXN * CYCLES_PER_TXN) * CLK_PERIOD;
  localparam int DRAIN_LIMIT = 200;

  logic      clk_i;
  logic      rst_ni;
  rf_wr_t    wr_i;
  logic      req_valid_i;
  rf_req_t   req_i;
  logic      req_credit_o;
  logic      rsp_valid_o;
  rf_rsp_t   rsp_o;
  // Driven only by the consumer process
  logic      rsp_credit_i = 1'b0;
  rf_fault_t fault_i;
  logic      alert_major_o;

  // Data each register should return, and whether a read must flag it
  rf_word_t  ref_data [`RF_NUM_REGS];
  logic      ref_err [`RF_NUM_REGS];
  // Expected responses in issue order
  rf_rsp_t   exp_q [$];
  int        req_credits;
  int        rsp_owed;
  int        rsp_seen;
  int        credit_pulses;
  bit        hold_credits;
  bit        random_stall;
  int        err_count;
  int        check_count;
  int        test_count;
  int        test_err_base;
  string     test_name;

  rf_ecc_top i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wr_i          (wr_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_credit_o  (req_credit_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .rsp_credit_i  (rsp_credit_i),
    .fault_i       (fault_i),
    .alert_major_o (alert_major_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic void check_value(string what, logic [31:0] expected, logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      $display("Fail %s %s expected %h actual %h", test_name, what, expected, actual);
      err_count++;
    end
  endfunction

  // Expected response built from the model at issue time
  function automatic rf_rsp_t model_rsp(rf_addr_t rs1, rf_addr_t rs2);
    rf_rsp_t rsp;
    rsp.rs1_data = ref_data[rs1];
    rsp.rs2_data = ref_data[rs2];
    rsp.rs1_err  = ref_err[rs1];
    rsp.rs2_err  = ref_err[rs2];
    return rsp;
  endfunction

  function automatic void check_response(rf_rsp_t act);
    rf_rsp_t exp;
    assert (exp_q.size() != 0) else begin
      $display("Response arrived in %s with no request outstanding", test_name);
      err_count++;
    end
    if (exp_q.size() != 0) begin
      exp = exp_q.pop_front();
      check_value("rs1 data", exp.rs1_data, act.rs1_data);
      check_value("rs2 data", exp.rs2_data, act.rs2_data);
      check_value("rs1 error", 32'(exp.rs1_err), 32'(act.rs1_err));
      check_value("rs2 error", 32'(exp.rs2_err), 32'(act.rs2_err));
    end
  endfunction

  // Outputs sampled at the rising edge, before the DUT updates
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (req_credit_o) begin
        req_credits++;
        credit_pulses++;
      end
      if (rsp_valid_o) begin
        rsp_seen++;
        rsp_owed++;
        check_response(rsp_o);
      end
    end
  end

  // Consumer hands back one credit per response, unless held or stalled
  always @(negedge clk_i) begin
    rsp_credit_i = 1'b0;
    if (rst_ni && !hold_credits && (rsp_owed > 0)) begin
      if (!random_stall || ($urandom_range(0, 2) == 0)) begin
        rsp_credit_i = 1'b1;
        rsp_owed--;
      end
    end
  end

  task automatic write_reg(rf_addr_t addr, rf_word_t data);
    @(negedge clk_i);
    wr_i.valid = 1'b1;
    wr_i.addr  = addr;
    wr_i.data  = data;
    // Index 0 is hardwired to zero
    if (addr != '0) begin
      ref_data[addr] = data;
      ref_err[addr]  = 1'b0;
    end
    @(negedge clk_i);
    wr_i.valid = 1'b0;
  endtask

  task automatic read_pair(rf_addr_t rs1, rf_addr_t rs2);
    @(negedge clk_i);
    // Only issue against a held request credit
    while (req_credits == 0) begin
      @(negedge clk_i);
    end
    req_valid_i = 1'b1;
    req_i.rs1   = rs1;
    req_i.rs2   = rs2;
    req_credits--;
    exp_q.push_back(model_rsp(rs1, rs2));
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic inject_fault(rf_addr_t addr, rf_fault_mode_e mode, rf_cw_t mask);
    @(negedge clk_i);
    fault_i.valid = 1'b1;
    fault_i.addr  = addr;
    fault_i.mode  = mode;
    fault_i.mask  = mask;
    case (mode)
      RF_FAULT_ZERO: ref_data[addr] = '0;
      RF_FAULT_ONE:  ref_data[addr] = '1;
      default:       ref_data[addr] = ref_data[addr] ^ mask[`RF_DATA_W-1:0];
    endcase
    // Detect-only code flags forced words and any 1 or 2 bit flip
    ref_err[addr] = 1'b1;
    @(negedge clk_i);
    fault_i.valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0) && (cycles < DRAIN_LIMIT)) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%0d requests in %s never got a response", exp_q.size(), test_name);
      err_count++;
      exp_q.delete();
    end
    // Let the trailing request credit pulses land
    repeat (3) @(negedge clk_i);
  endtask

  task automatic begin_test(string name);
    test_name     = name;
    test_err_base = err_count;
    test_count++;
  endtask

  task automatic end_test();
    $display("Test %0d %s done, %0d errors", test_count, test_name, err_count - test_err_base);
  endtask

  `include "tb_rf_ecc_tests.svh"

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, tests still running after %0d ns", WATCHDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    wr_i        = '0;
    req_valid_i = 1'b0;
    req_i       = '0;
    fault_i     = '0;
    req_credits   = `RF_REQ_CREDITS;
    rsp_owed      = 0;
    rsp_seen      = 0;
    credit_pulses = 0;
    hold_credits  = 1'b0;
    random_stall  = 1'b0;
    err_count     = 0;
    check_count   = 0;
    test_count    = 0;
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      ref_data[i] = '0;
      ref_err[i]  = 1'b0;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_state();
    test_random_writes();
    test_xor_faults();
    test_forced_words();
    test_backpressure();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* rtl/rf_alert_monitor.sv */
`include "rf_ecc_macros.svh"

module rf_alert_monitor import rf_ecc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     err_valid_i,
  input  rf_wr_t   wr_i,
  input  rf_cw_t   mem_i [`RF_NUM_REGS],
  input  rf_addr_t rs1_i,
  input  rf_addr_t rs2_i,
  input  logic     check_valid_i,
  output logic     alert_major_o
);

  logic                    alert_q;
  // Architectural data as written, unaffected by glitches
  rf_word_t                shadow_q [`RF_NUM_REGS];
  // Words that must be flagged when read
  logic [`RF_NUM_REGS-1:0] bad;
  logic [`RF_NUM_REGS-1:0] bad_q;
  logic                    reset_state;

  // Sticky major alert, cleared by reset only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else if (err_valid_i) begin
      alert_q <= 1'b1;
    end
  end

  assign alert_major_o = alert_q;

  // Shadow follows the write port the same way as storage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `RF_NUM_REGS; i++) begin
        shadow_q[i] <= '0;
      end
    end else if (wr_i.valid && (wr_i.addr != '0)) begin
      shadow_q[wr_i.addr] <= wr_i.data;
    end
  end

  // Per word, small data flips against shadow or a stuck all-0/all-1 word
  always_comb begin
    reset_state = 1'b1;
    for (int a = 0; a < `RF_NUM_REGS; a++) begin
      bad[a] = ($countones(mem_i[a][`RF_DATA_W-1:0] ^ shadow_q[a]) inside {1, 2})
               || (mem_i[a] == '0) || (mem_i[a] == '1);
      reset_state = reset_state && (mem_i[a] == RF_CW_RESET) && (shadow_q[a] == '0);
    end
  end

  // Snapshot of the read cycle, lines up with the check stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bad_q <= '0;
    end else begin
      bad_q <= bad;
    end
  end

  // Storage and shadow leave reset as encoded zero
  a_reset_values: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rst_ni) |-> reset_state)
    else $error("Storage not zero with check bits 2A after reset");

  // Reading a corrupted word raises the alert at the next edge
  a_fault_raises_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (check_valid_i && (bad_q[rs1_i] || bad_q[rs2_i])) |=> alert_major_o)
    else $error("Corrupted operand read without a major alert");

  // Written word in storage agrees with the shadow, unless a glitch landed with it
  a_shadow_update: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_i.valid && (wr_i.addr != '0)) |=>
      ((mem_i[$past(wr_i.addr)][`RF_DATA_W-1:0] == shadow_q[$past(wr_i.addr)])
       || bad[$past(wr_i.addr)]))
    else $error("Shadow memory and storage disagree after a write");

endmodule

/* rtl/rf_check_stage.sv */
`include "rf_ecc_macros.svh"

module rf_check_stage import rf_ecc_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    valid_i,
  input  rf_cw_t  cw1_i,
  input  rf_cw_t  cw2_i,
  input  logic    rsp_credit_i,
  output logic    rsp_valid_o,
  output rf_rsp_t rsp_o,
  output logic    slot_free_o,
  output logic    err_valid_o
);

  localparam int DEPTH = `RF_REQ_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int RCR_W = $clog2(`RF_RSP_CREDITS + 1);

  rf_rsp_t           fifo_q [DEPTH];
  logic [PTR_W-1:0]  wptr_q;
  logic [PTR_W-1:0]  rptr_q;
  logic [CNT_W-1:0]  count_q;
  logic [RCR_W-1:0]  credits_q;
  logic              err1;
  logic              err2;
  logic              push;
  logic              pop;
  rf_rsp_t           rsp_in;

  // One checker per operand
  rf_ecc_codec i_chk1 (
    .data_i ('0),
    .cw_i   (cw1_i),
    .cw_o   (),
    .err_o  (err1)
  );

  rf_ecc_codec i_chk2 (
    .data_i ('0),
    .cw_i   (cw2_i),
    .cw_o   (),
    .err_o  (err2)
  );

  // Checked response, data passed as stored
  always_comb begin
    rsp_in.rs1_data = cw1_i[`RF_DATA_W-1:0];
    rsp_in.rs2_data = cw2_i[`RF_DATA_W-1:0];
    rsp_in.rs1_err  = err1;
    rsp_in.rs2_err  = err2;
  end

  assign push = valid_i;
  // Drain while a downstream credit is held
  assign pop  = (count_q != '0) && (credits_q != '0);

  // Buffer control and downstream credit count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q    <= '0;
      rptr_q    <= '0;
      count_q   <= '0;
      credits_q <= RCR_W'(`RF_RSP_CREDITS);
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      count_q   <= count_q + CNT_W'(push) - CNT_W'(pop);
      credits_q <= credits_q - RCR_W'(pop) + RCR_W'(rsp_credit_i);
    end
  end

  // Buffer storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wptr_q] <= rsp_in;
    end
  end

  // Head of buffer goes out in the cycle it is popped
  assign rsp_valid_o = pop;
  assign rsp_o       = fifo_q[rptr_q];
  assign slot_free_o = pop;
  // Any operand error feeds the alert
  assign err_valid_o = valid_i && (err1 || err2);

  // Request credits bound the occupancy
  a_fifo_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push && !pop) |-> (count_q < CNT_W'(DEPTH)))
    else $error("Response buffer overflow");

  // Consumer never returns more credits than it was given
  a_rsp_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credits_q <= RCR_W'(`RF_RSP_CREDITS))
    else $error("Response credit count above its initial value");

endmodule

/* rtl/rf_ecc_codec.sv */
`include "rf_ecc_macros.svh"

module rf_ecc_codec import rf_ecc_pkg::*; (
  input  rf_word_t data_i,
  input  rf_cw_t   cw_i,
  output rf_cw_t   cw_o,
  output logic     err_o
);

  // Parity check matrix, one column per data bit
  // Columns are distinct and have weight two or more, check bits take the unit columns
  // So every single or double flip over the 38 bits leaves a nonzero syndrome
  // Row parities give 18 hex for all-ones data, which keeps all-0 and all-1 words invalid
  localparam logic [`RF_ECC_W-1:0] H_COL [`RF_DATA_W] = '{
    6'h03, 6'h05, 6'h06, 6'h07, 6'h09, 6'h0A, 6'h0B, 6'h0C,
    6'h0D, 6'h0E, 6'h0F, 6'h11, 6'h12, 6'h13, 6'h14, 6'h15,
    6'h16, 6'h17, 6'h18, 6'h19, 6'h1A, 6'h1B, 6'h1C, 6'h1D,
    6'h1E, 6'h1F, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26
  };

  logic [`RF_ECC_W-1:0] syndrome;

  // Check bits of a data word, inverted by the reset pattern
  function automatic logic [`RF_ECC_W-1:0] calc_ecc(rf_word_t data);
    logic [`RF_ECC_W-1:0] ecc;
    ecc = `RF_ECC_RESET;
    for (int j = 0; j < `RF_DATA_W; j++) begin
      if (data[j]) begin
        ecc = ecc ^ H_COL[j];
      end
    end
    return ecc;
  endfunction

  // Encoder side
  assign cw_o = {calc_ecc(data_i), data_i};

  // Checker side, recompute and compare against stored check bits
  assign syndrome = calc_ecc(cw_i[`RF_DATA_W-1:0]) ^ cw_i[`RF_ECC_W+`RF_DATA_W-1:`RF_DATA_W];

  // Detect only, no correction attempted
  assign err_o = |syndrome;

endmodule

/* rtl/rf_ecc_macros.svh */
`ifndef RF_ECC_MACROS_SVH
`define RF_ECC_MACROS_SVH

// Register file geometry
`define RF_NUM_REGS 32
`define RF_DATA_W 32

// Check bits per word, stored above the data bits
`define RF_ECC_W 6

// Inverted check bits of an all-zero data word
`define RF_ECC_RESET 6'h2A

// Response buffer depth, equal to the request credits granted after reset
`define RF_REQ_CREDITS 4

// Downstream response credits held after reset
`define RF_RSP_CREDITS 2

`endif

/* rtl/rf_ecc_pkg.sv */
`include "rf_ecc_macros.svh"

package rf_ecc_pkg;

  // Register index, data word and stored codeword
  typedef logic [$clog2(`RF_NUM_REGS)-1:0] rf_addr_t;
  typedef logic [`RF_DATA_W-1:0] rf_word_t;
  // Check bits sit above the data bits
  typedef logic [`RF_ECC_W+`RF_DATA_W-1:0] rf_cw_t;

  // Codeword of a cleared register
  localparam rf_cw_t RF_CW_RESET = {`RF_ECC_RESET, {`RF_DATA_W{1'b0}}};

  // Write port command
  typedef struct packed {
    logic     valid;
    rf_addr_t addr;
    rf_word_t data;
  } rf_wr_t;

  // Two-operand read request, qualified by a separate valid
  typedef struct packed {
    rf_addr_t rs1;
    rf_addr_t rs2;
  } rf_req_t;

  // Read response with one error flag per operand
  typedef struct packed {
    rf_word_t rs1_data;
    rf_word_t rs2_data;
    logic     rs1_err;
    logic     rs2_err;
  } rf_rsp_t;

  // Glitch emulation modes
  typedef enum logic [1:0] {
    RF_FAULT_XOR  = 2'd0,
    RF_FAULT_ZERO = 2'd1,
    RF_FAULT_ONE  = 2'd2
  } rf_fault_mode_e;

  // Fault injection command
  typedef struct packed {
    logic           valid;
    rf_addr_t       addr;
    rf_fault_mode_e mode;
    rf_cw_t         mask;
  } rf_fault_t;

endpackage

/* rtl/rf_ecc_regfile.sv */
`include "rf_ecc_macros.svh"

module rf_ecc_regfile import rf_ecc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rf_wr_t    wr_i,
  input  rf_fault_t fault_i,
  input  rf_addr_t  raddr1_i,
  input  rf_addr_t  raddr2_i,
  output rf_cw_t    rdata1_o,
  output rf_cw_t    rdata2_o,
  output rf_cw_t    mem_o [`RF_NUM_REGS]
);

  rf_cw_t mem_q [`RF_NUM_REGS];
  rf_cw_t wr_cw;
  rf_cw_t fault_base;
  rf_cw_t fault_cw;
  logic   wr_en;

  // Encoder for the write port
  rf_ecc_codec i_wr_enc (
    .data_i (wr_i.data),
    .cw_i   ('0),
    .cw_o   (wr_cw),
    .err_o  ()
  );

  // Register 0 is hardwired to zero
  assign wr_en = wr_i.valid && (wr_i.addr != '0);

  // Fault lands on top of a same-cycle write to the same register
  always_comb begin
    if (wr_en && (wr_i.addr == fault_i.addr)) begin
      fault_base = wr_cw;
    end else begin
      fault_base = mem_q[fault_i.addr];
    end
    case (fault_i.mode)
      RF_FAULT_ZERO: fault_cw = '0;
      RF_FAULT_ONE:  fault_cw = '1;
      default:       fault_cw = fault_base ^ fault_i.mask;
    endcase
  end

  // Storage, every word starts as encoded zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `RF_NUM_REGS; i++) begin
        mem_q[i] <= RF_CW_RESET;
      end
    end else begin
      if (wr_en) begin
        mem_q[wr_i.addr] <= wr_cw;
      end
      // Later assignment wins, fault has priority
      if (fault_i.valid) begin
        mem_q[fault_i.addr] <= fault_cw;
      end
    end
  end

  // Raw read ports, checked downstream
  assign rdata1_o = mem_q[raddr1_i];
  assign rdata2_o = mem_q[raddr2_i];

  // Full storage view for the monitor
  assign mem_o = mem_q;

  // Register 0 only moves under a glitch aimed at it
  a_reg0_not_written: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $changed(mem_q[0]) |-> $past(fault_i.valid && (fault_i.addr == '0)))
    else $error("Register 0 changed without a fault targeting it");

endmodule

/* rtl/rf_ecc_top.sv */
`include "rf_ecc_macros.svh"

module rf_ecc_top import rf_ecc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rf_wr_t    wr_i,
  input  logic      req_valid_i,
  input  rf_req_t   req_i,
  output logic      req_credit_o,
  output logic      rsp_valid_o,
  output rf_rsp_t   rsp_o,
  input  logic      rsp_credit_i,
  input  rf_fault_t fault_i,
  output logic      alert_major_o
);

  // Storage read path
  rf_addr_t raddr1;
  rf_addr_t raddr2;
  rf_cw_t   rdata1;
  rf_cw_t   rdata2;
  rf_cw_t   mem [`RF_NUM_REGS];
  // Read stage to check stage
  logic     rd_valid;
  rf_cw_t   cw1;
  rf_cw_t   cw2;
  rf_addr_t rs1;
  rf_addr_t rs2;
  // Check stage feedback and alert source
  logic     slot_free;
  logic     err_valid;

  rf_ecc_regfile i_regfile (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_i     (wr_i),
    .fault_i  (fault_i),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .mem_o    (mem)
  );

  rf_read_stage i_read_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .slot_free_i  (slot_free),
    .raddr1_o     (raddr1),
    .raddr2_o     (raddr2),
    .valid_o      (rd_valid),
    .cw1_o        (cw1),
    .cw2_o        (cw2),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .req_credit_o (req_credit_o)
  );

  rf_check_stage i_check_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (rd_valid),
    .cw1_i        (cw1),
    .cw2_i        (cw2),
    .rsp_credit_i (rsp_credit_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .slot_free_o  (slot_free),
    .err_valid_o  (err_valid)
  );

  rf_alert_monitor i_alert_monitor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .err_valid_i   (err_valid),
    .wr_i          (wr_i),
    .mem_i         (mem),
    .rs1_i         (rs1),
    .rs2_i         (rs2),
    .check_valid_i (rd_valid),
    .alert_major_o (alert_major_o)
  );

endmodule

/* rtl/rf_read_stage.sv */
`include "rf_ecc_macros.svh"

module rf_read_stage import rf_ecc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_valid_i,
  input  rf_req_t  req_i,
  input  rf_cw_t   rdata1_i,
  input  rf_cw_t   rdata2_i,
  input  logic     slot_free_i,
  output rf_addr_t raddr1_o,
  output rf_addr_t raddr2_o,
  output logic     valid_o,
  output rf_cw_t   cw1_o,
  output rf_cw_t   cw2_o,
  output rf_addr_t rs1_o,
  output rf_addr_t rs2_o,
  output logic     req_credit_o
);

  localparam int CRED_W = $clog2(`RF_REQ_CREDITS + 1);

  // Mirror of the credits held upstream
  logic [CRED_W-1:0] credits_q;
  logic              credit_q;
  // Accepted request, addresses the storage in the next cycle
  logic              rd_valid_q;
  rf_req_t           rd_req_q;
  // Codewords and addresses handed to the check stage
  logic              valid_q;
  rf_cw_t            cw1_q;
  rf_cw_t            cw2_q;
  rf_addr_t          rs1_q;
  rf_addr_t          rs2_q;

  // Credit bookkeeping, one returned per freed buffer slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q  <= CRED_W'(`RF_REQ_CREDITS);
      credit_q   <= 1'b0;
      rd_valid_q <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      credits_q  <= credits_q - CRED_W'(req_valid_i) + CRED_W'(credit_q);
      credit_q   <= slot_free_i;
      rd_valid_q <= req_valid_i;
      valid_q    <= rd_valid_q;
    end
  end

  // Request capture
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rd_req_q <= req_i;
    end
  end

  // Operand capture, sees writes up to the accepting edge
  always_ff @(posedge clk_i) begin
    if (rd_valid_q) begin
      cw1_q <= rdata1_i;
      cw2_q <= rdata2_i;
      rs1_q <= rd_req_q.rs1;
      rs2_q <= rd_req_q.rs2;
    end
  end

  assign raddr1_o     = rd_req_q.rs1;
  assign raddr2_o     = rd_req_q.rs2;
  assign valid_o      = valid_q;
  assign cw1_o        = cw1_q;
  assign cw2_o        = cw2_q;
  assign rs1_o        = rs1_q;
  assign rs2_o        = rs2_q;
  assign req_credit_o = credit_q;

  // Upstream only issues against a held credit
  a_req_has_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> (credits_q != '0))
    else $error("Request issued without a request credit");

endmodule

/* verilog.f */
+incdir+rtl
+incdir+dv
rtl/rf_ecc_pkg.sv
rtl/rf_ecc_codec.sv
rtl/rf_ecc_regfile.sv
rtl/rf_read_stage.sv
rtl/rf_check_stage.sv
rtl/rf_alert_monitor.sv
rtl/rf_ecc_top.sv
dv/tb_rf_ecc.sv
